/* flist.f */
hw/soc_pkg.sv
hw/reset_gen.sv
hw/iomem_decoder.sv
hw/gpio_regs.sv
hw/uart_ctrl.sv
hw/hx8k_top.sv
sim/hx8k_asserts.sv
sim/tb_hx8k.sv

/* hw/gpio_regs.sv */
// GPIO register
// One 32-bit word with byte-strobed writes and readback; the low byte drives the LEDs
`timescale 1ns/1ps

module gpio_regs (
	input  logic                           clk,
	input  logic                           sys_resetn,
	input  soc_pkg::iomem_req_t            req,
	output soc_pkg::iomem_rsp_t            rsp,
	output logic [soc_pkg::LED_WIDTH-1:0]  leds
);

	logic [31:0] gpio_q;

	always_ff @(posedge clk) begin
		if (!sys_resetn) begin
			gpio_q    <= 32'd0;
			rsp.ready <= 1'b0;
		end else begin
			rsp.ready <= 1'b0;                 // Ready is a pulse
			if (req.valid && !rsp.ready) begin // Ignore the held request during its ready cycle
				rsp.ready <= 1'b1;
				rsp.rdata <= gpio_q;           // Old value, even on a write
				for (int i = 0; i < 4; i++) begin
					if (req.wstrb[i])
						gpio_q[i*8 +: 8] <= req.wdata[i*8 +: 8];
				end
			end
		end
	end

	assign leds = gpio_q[soc_pkg::LED_WIDTH-1:0];

endmodule

/* hw/hx8k_top.sv */
// Board top level
// Reset stretcher, iomem decoder, GPIO and UART around the external iomem master port
`timescale 1ns/1ps

module hx8k_top (
	input  logic                          clk,
	input  logic                          resetn,
	input  soc_pkg::iomem_req_t           bus_req,  // Master port, driven by the CPU side
	output soc_pkg::iomem_rsp_t           bus_rsp,
	output logic [soc_pkg::LED_WIDTH-1:0] leds,
	output logic                          ser_tx,
	input  logic                          ser_rx
);

	logic                sys_resetn; // Stretched internal reset
	soc_pkg::iomem_req_t gpio_req;
	soc_pkg::iomem_rsp_t gpio_rsp;
	soc_pkg::iomem_req_t uart_req;
	soc_pkg::iomem_rsp_t uart_rsp;

	reset_gen u_reset_gen (
		.clk        (clk),
		.resetn     (resetn),
		.sys_resetn (sys_resetn)
	);

	iomem_decoder u_decoder (
		.clk        (clk),
		.sys_resetn (sys_resetn),
		.bus_req    (bus_req),
		.bus_rsp    (bus_rsp),
		.gpio_req   (gpio_req),
		.gpio_rsp   (gpio_rsp),
		.uart_req   (uart_req),
		.uart_rsp   (uart_rsp)
	);

	// Region 03
	gpio_regs u_gpio (
		.clk        (clk),
		.sys_resetn (sys_resetn),
		.req        (gpio_req),
		.rsp        (gpio_rsp),
		.leds       (leds)
	);

	// Region 02
	uart_ctrl u_uart (
		.clk        (clk),
		.sys_resetn (sys_resetn),
		.req        (uart_req),
		.rsp        (uart_rsp),
		.ser_tx     (ser_tx),
		.ser_rx     (ser_rx)
	);

endmodule

/* hw/iomem_decoder.sv */
// iomem address decoder
// Routes a request to one peripheral by region and merges responses; answers unmapped regions
`timescale 1ns/1ps

module iomem_decoder (
	input  logic                clk,
	input  logic                sys_resetn,

	input  soc_pkg::iomem_req_t bus_req,   // From the master
	output soc_pkg::iomem_rsp_t bus_rsp,

	output soc_pkg::iomem_req_t gpio_req,
	input  soc_pkg::iomem_rsp_t gpio_rsp,

	output soc_pkg::iomem_req_t uart_req,
	input  soc_pkg::iomem_rsp_t uart_rsp
);

	logic [7:0] region;
	logic       gpio_hit;
	logic       uart_hit;
	logic       unmapped_sel;
	logic       unmapped_ready; // Responder for regions with no peripheral

	assign region   = bus_req.addr.fields.region;
	assign gpio_hit = (region == soc_pkg::REGION_GPIO);
	assign uart_hit = (region == soc_pkg::REGION_UART);

	// Valid for an access that no peripheral claims
	assign unmapped_sel = bus_req.valid && !gpio_hit && !uart_hit;

	// Each peripheral sees the full request, but only its own valid
	always_comb begin
		gpio_req       = bus_req;
		gpio_req.valid = bus_req.valid && gpio_hit;
		uart_req       = bus_req;
		uart_req.valid = bus_req.valid && uart_hit;
	end

	// One-cycle dummy reply so the master never hangs on a bad address
	always_ff @(posedge clk) begin
		if (!sys_resetn) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= unmapped_sel && !unmapped_ready; // Single pulse per request
		end
	end

	// At most one responder is active; gate rdata by ready and OR together
	always_comb begin
		bus_rsp.ready = gpio_rsp.ready | uart_rsp.ready | unmapped_ready;
		bus_rsp.rdata = (gpio_rsp.rdata & {32{gpio_rsp.ready}})
			| (uart_rsp.rdata & {32{uart_rsp.ready}}); // Unmapped reads return zero
	end

endmodule

/* hw/reset_gen.sv */
// Power-on reset stretcher
// Holds the internal reset low until the external reset has been high for RESET_HOLD cycles
`timescale 1ns/1ps

module reset_gen (
	input  logic clk,
	input  logic resetn,     // External reset, active low
	output logic sys_resetn  // Clean internal reset, active low
);

	logic [5:0] hold_cnt;    // Saturates at RESET_HOLD

	always_ff @(posedge clk) begin
		if (!resetn) begin
			hold_cnt <= 6'd0;    // Any low restarts the stretch
		end else if (hold_cnt != soc_pkg::RESET_HOLD) begin
			hold_cnt <= hold_cnt + 6'd1;
		end
	end

	// Released only once the counter has filled
	assign sys_resetn = (hold_cnt == soc_pkg::RESET_HOLD);

endmodule

/* hw/soc_pkg.sv */
// Shared definitions for the board-level SoC subsystem
// Bus request and response structs, address views, region codes and peripheral constants
package soc_pkg;

	// Address word, decoded as a region by the decoder and as a register index by peripherals
	typedef union packed {
		logic [31:0] flat;    // Whole address word
		struct packed {
			logic [7:0]  region;    // Top byte selects the peripheral
			logic [21:0] reg_index; // Word index inside the peripheral
			logic [1:0]  byte_sel;  // Byte within the word, unused by word registers
		} fields;
	} iomem_addr_t;

	// Master to peripheral
	typedef struct packed {
		logic        valid;    // Request present, held until ready
		logic [3:0]  wstrb;    // Nonzero means write
		iomem_addr_t addr;
		logic [31:0] wdata;
	} iomem_req_t;

	// Peripheral to master
	typedef struct packed {
		logic        ready;    // One-cycle completion pulse
		logic [31:0] rdata;    // Valid while ready is high
	} iomem_rsp_t;

	// Region codes in addr[31:24]
	localparam logic [7:0] REGION_UART = 8'h02;
	localparam logic [7:0] REGION_GPIO = 8'h03;

	// UART register map by word index
	localparam logic [21:0] UART_REG_DIV  = 22'd0; // Clocks per serial bit
	localparam logic [21:0] UART_REG_DATA = 22'd1; // Write sends, read takes the rx byte

	// Internal reset stretch in clock cycles
	localparam logic [5:0] RESET_HOLD = 6'd16;

	// Eight clocks per bit out of reset
	localparam logic [31:0] UART_DIV_RESET = 32'd8;

	// Data read result with nothing buffered
	localparam logic [31:0] UART_RX_EMPTY = 32'hFFFF_FFFF;

	// LED pins on the board
	localparam int LED_WIDTH = 8;

endpackage

/* hw/uart_ctrl.sv */
// UART peripheral on the iomem bus
// Divider register, 8N1 transmit shifter with write back-pressure, one-byte receive buffer
`timescale 1ns/1ps

module uart_ctrl (
	input  logic                clk,
	input  logic                sys_resetn,
	input  soc_pkg::iomem_req_t req,
	output soc_pkg::iomem_rsp_t rsp,
	output logic                ser_tx,
	input  logic                ser_rx
);

	logic [31:0] div_q;        // Clocks per bit

	// Bus decode
	logic        req_write;
	logic        sel_div;
	logic        sel_data;
	logic        req_new;      // Valid and not already answered
	logic        rx_take;      // Data read empties the buffer

	// Transmit
	logic [9:0]  tx_pattern;   // Stop, data, start; LSB is on the wire
	logic [3:0]  tx_bitcnt;    // Bits still to send
	logic [31:0] tx_divcnt;
	logic        tx_busy;
	logic        tx_bit_done;

	// Receive
	logic [1:0]  rx_sync;      // Two-flop synchronizer
	logic        rx_in;
	logic        rx_active;
	logic [3:0]  rx_bitcnt;    // 0 start half bit, 1..8 data, 9 stop
	logic [31:0] rx_divcnt;
	logic [7:0]  rx_shift;
	logic [7:0]  rx_buf;
	logic        rx_valid;
	logic        rx_half_done;
	logic        rx_bit_done;

	assign req_write = (req.wstrb != 4'd0);
	assign sel_div   = (req.addr.fields.reg_index == soc_pkg::UART_REG_DIV);
	assign sel_data  = (req.addr.fields.reg_index == soc_pkg::UART_REG_DATA);
	assign req_new   = req.valid && !rsp.ready;
	assign rx_take   = req_new && !req_write && sel_data;

	assign tx_busy     = (tx_bitcnt != 4'd0);
	assign tx_bit_done = (tx_divcnt + 32'd1 >= div_q); // Divider of 0 acts as 1
	assign ser_tx      = tx_pattern[0];

	// Bus registers and transmit shifter
	always_ff @(posedge clk) begin
		if (!sys_resetn) begin
			rsp.ready  <= 1'b0;
			div_q      <= soc_pkg::UART_DIV_RESET;
			tx_pattern <= 10'h3FF;                // Line idles high
			tx_bitcnt  <= 4'd0;
			tx_divcnt  <= 32'd0;
		end else begin
			rsp.ready <= 1'b0;
			if (req_new) begin
				if (sel_div) begin
					rsp.ready <= 1'b1;
					rsp.rdata <= div_q;
					for (int i = 0; i < 4; i++) begin
						if (req.wstrb[i])
							div_q[i*8 +: 8] <= req.wdata[i*8 +: 8];
					end
				end else if (sel_data && req_write) begin
					if (!tx_busy) begin             // Otherwise stall until the frame ends
						rsp.ready  <= 1'b1;
						rsp.rdata  <= 32'd0;
						tx_pattern <= {1'b1, req.wdata[7:0], 1'b0};
						tx_bitcnt  <= 4'd10;
						tx_divcnt  <= 32'd0;
					end
				end else if (sel_data) begin
					rsp.ready <= 1'b1;
					rsp.rdata <= rx_valid ? {24'd0, rx_buf} : soc_pkg::UART_RX_EMPTY;
				end else begin
					// Unused index inside the UART region
					rsp.ready <= 1'b1;
					rsp.rdata <= 32'd0;
				end
			end

			// Shift one bit out every divider period
			if (tx_busy) begin
				if (tx_bit_done) begin
					tx_pattern <= {1'b1, tx_pattern[9:1]};
					tx_bitcnt  <= tx_bitcnt - 4'd1;
					tx_divcnt  <= 32'd0;
				end else begin
					tx_divcnt <= tx_divcnt + 32'd1;
				end
			end
		end
	end

	assign rx_in        = rx_sync[1];
	assign rx_half_done = ({rx_divcnt + 32'd1, 1'b0} >= {1'b0, div_q}); // Half a bit elapsed
	assign rx_bit_done  = (rx_divcnt + 32'd1 >= div_q);

	// Receive state machine with mid-bit sampling
	always_ff @(posedge clk) begin
		if (!sys_resetn) begin
			rx_sync   <= 2'b11;
			rx_active <= 1'b0;
			rx_bitcnt <= 4'd0;
			rx_divcnt <= 32'd0;
			rx_valid  <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], ser_rx};
			if (rx_take)
				rx_valid <= 1'b0;                   // Set below wins if a byte lands now

			if (!rx_active) begin
				if (!rx_in) begin                   // Falling edge of a start bit
					rx_active <= 1'b1;
					rx_bitcnt <= 4'd0;
					rx_divcnt <= 32'd0;
				end
			end else if (rx_bitcnt == 4'd0) begin
				if (rx_half_done) begin
					rx_divcnt <= 32'd0;
					if (rx_in)
						rx_active <= 1'b0;          // Glitch, not a real start bit
					else
						rx_bitcnt <= 4'd1;
				end else begin
					rx_divcnt <= rx_divcnt + 32'd1;
				end
			end else if (rx_bit_done) begin
				rx_divcnt <= 32'd0;
				rx_bitcnt <= rx_bitcnt + 4'd1;
				if (rx_bitcnt == 4'd9) begin        // Middle of the stop bit
					rx_active <= 1'b0;
					rx_buf    <= rx_shift;          // Overwrites an unread byte
					rx_valid  <= 1'b1;
				end else begin
					rx_shift <= {rx_in, rx_shift[7:1]}; // LSB first
				end
			end else begin
				rx_divcnt <= rx_divcnt + 32'd1;
			end
		end
	end

endmodule

/* sim/hx8k_asserts.sv */
// Bound checks for the board top level
// Bus ready pulse rules and pin state during internal reset
`timescale 1ns/1ps

module hx8k_asserts (
	input logic                          clk,
	input logic                          sys_resetn,
	input soc_pkg::iomem_req_t           bus_req,
	input soc_pkg::iomem_rsp_t           bus_rsp,
	input logic [soc_pkg::LED_WIDTH-1:0] leds,
	input logic                          ser_tx
);

	int assert_fails = 0; // Failure count, read at the end of the run

	// Ready is a one-cycle pulse
	ready_single: assert property (@(posedge clk) disable iff (!sys_resetn)
		bus_rsp.ready |=> !bus_rsp.ready)
		else begin
			$error("bus ready was high for two cycles in a row");
			assert_fails++;
		end

	// Every ready answers a request seen the cycle before
	ready_after_valid: assert property (@(posedge clk) disable iff (!sys_resetn)
		bus_rsp.ready |-> $past(bus_req.valid))
		else begin
			$error("bus ready without valid on the previous cycle");
			assert_fails++;
		end

	// Pins settle once internal reset has been low for a couple of edges
	reset_pins: assert property (@(posedge clk)
		(!sys_resetn && $past(!sys_resetn) && $past(!sys_resetn, 2)) |-> (ser_tx && leds == '0))
		else begin
			$error("ser_tx or leds wrong while internal reset is low");
			assert_fails++;
		end

endmodule

bind hx8k_top hx8k_asserts u_asserts (
	.clk        (clk),
	.sys_resetn (sys_resetn),
	.bus_req    (bus_req),
	.bus_rsp    (bus_rsp),
	.leds       (leds),
	.ser_tx     (ser_tx)
);

/* sim/hx8k_testdata.txt */
# W addr wdata wstrb name | R addr expected name
# S byte_sent_on_ser_rx name | T byte_expected_on_ser_tx name
R 02000000 00000008 reset_div
R 03000000 00000000 reset_gpio
W 03000000 12345678 f gpio_full
R 03000000 12345678 gpio_read_full
W 03000000 aabbccdd 2 gpio_byte1
R 03000000 1234cc78 gpio_read_byte1
W 03000000 aabbccdd 9 gpio_bytes03
R 03000000 aa34ccdd gpio_read_bytes03
W 03000000 0000ee00 4 gpio_byte2
R 03000000 aa00ccdd gpio_read_byte2
R 05000000 00000000 unmapped_read
W 07000010 deadbeef f unmapped_write
R 03000000 aa00ccdd gpio_after_unmapped
W 02000008 ffffffff f uart_spare_write
R 03000000 aa00ccdd gpio_after_uart
W 02000000 00000006 1 div_set
R 02000000 00000006 div_read
W 03000000 00005500 2 gpio_byte1_again
R 02000000 00000006 div_after_gpio
R 03000000 aa0055dd gpio_read_again
W 02000004 000000a5 1 tx_first
W 02000004 0000003c 1 tx_second
T a5 tx_frame_first
T 3c tx_frame_second
S 5a rx_frame
R 02000004 0000005a rx_read
R 02000004 ffffffff rx_empty
S 11 rx_frame_old
S c3 rx_frame_new
R 02000004 000000c3 rx_overwrite
R 02000004 ffffffff rx_empty_again

/* sim/tb_hx8k.sv */
// Testbench for the board top level
// Replays bus reads and writes, serial sends and serial checks from a data file
`timescale 1ns/1ps

module tb_hx8k;

	localparam int READY_TIMEOUT = 4000; // Cycles, covers a full frame of back-pressure
	localparam int FRAME_TIMEOUT = 4000; // Cycles to wait for a decoded ser_tx byte

	logic                          clk;
	logic                          resetn;
	soc_pkg::iomem_req_t           bus_req;
	soc_pkg::iomem_rsp_t           bus_rsp;
	logic [soc_pkg::LED_WIDTH-1:0] leds;
	logic                          ser_tx;
	logic                          ser_rx;

	logic [31:0] lcg_state;
	logic [31:0] gpio_model;      // Expected GPIO register
	logic [31:0] div_model;       // Expected clocks per serial bit
	logic [7:0]  tx_seen[$];      // Bytes decoded from ser_tx, oldest first
	logic        tx_frame_active; // Monitor is inside a frame
	int          tests_run;
	int          tests_failed;
	logic        aborted;         // A timeout or bad input ends the run early

	hx8k_top dut (
		.clk     (clk),
		.resetn  (resetn),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.leds    (leds),
		.ser_tx  (ser_tx),
		.ser_rx  (ser_rx)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte-strobed register write rule
	function automatic logic [31:0] apply_strobes(input logic [31:0] old_val,
		input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] res;
		res = old_val;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[i*8 +: 8] = data[i*8 +: 8];
		end
		return res;
	endfunction

	task automatic report_ok(input string name);
		tests_run++;
		$display("%s ok", name);
	endtask

	task automatic report_value_error(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		tests_run++;
		tests_failed++;
		$display("Error: %s expected %h actual %h", name, expected, actual);
	endtask

	task automatic report_failure(input string name, input string what);
		tests_run++;
		tests_failed++;
		$display("%s failed: %s", name, what);
	endtask

	// Called at 1 ns after a rising edge, returns at the same phase
	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#1;
		end
	endtask

	// One iomem transfer, request held until ready is seen
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wstrb, output logic [31:0] rdata, output int waited,
		output logic timed_out);
		bus_req.valid     = 1'b1;
		bus_req.addr.flat = addr;
		bus_req.wdata     = wdata;
		bus_req.wstrb     = wstrb;
		waited    = 0;
		timed_out = 1'b0;
		rdata     = 32'd0;
		do begin
			@(negedge clk);                  // Ready is stable mid-cycle
			waited++;
		end while (bus_rsp.ready !== 1'b1 && waited < READY_TIMEOUT);
		if (bus_rsp.ready === 1'b1)
			rdata = bus_rsp.rdata;
		else
			timed_out = 1'b1;
		@(posedge clk);
		#1;
		bus_req.valid = 1'b0;                // Dropped in the cycle after ready
	endtask

	// 8N1 frame on ser_rx at the current divider rate
	task automatic send_frame(input logic [7:0] data);
		logic [9:0] bits;
		bits = {1'b1, data, 1'b0};
		for (int b = 0; b < 10; b++) begin
			ser_rx = bits[b];
			idle_cycles(div_model);
		end
	endtask

	// Decodes ser_tx and checks every bit lasts exactly one divider period
	task automatic watch_tx();
		logic [9:0] bits;
		logic       bad;
		int         len;
		forever begin
			@(negedge clk);
			if (ser_tx === 1'b0) begin           // Start bit seen
				tx_frame_active = 1'b1;
				len  = div_model;
				bad  = 1'b0;
				bits = '0;
				for (int n = 0; n < 10 * len; n++) begin
					if (n > 0)
						@(negedge clk);
					if (n % len == 0)
						bits[n / len] = ser_tx; // First sample of each bit
					else if (ser_tx !== bits[n / len])
						bad = 1'b1;
				end
				if (bad || bits[9] !== 1'b1)
					report_failure("tx_frame_timing", "ser_tx bit length or stop bit is wrong");
				tx_seen.push_back(bits[8:1]);
				tx_frame_active = 1'b0;
			end
		end
	endtask

	initial begin
		logic [31:0]      addr;
		logic [31:0]      data;
		logic [31:0]      expected;
		logic [31:0]      rdata;
		logic [3:0]       strb;
		logic [7:0]       byte_val;
		logic [7:0]       got;
		logic             timed_out;
		logic             busy_before;
		logic [8*128-1:0] skip_line;
		string            op;
		string            name;
		int               fd;
		int               waited;

		resetn          = 1'b0;
		bus_req         = '0;
		ser_rx          = 1'b1;             // Serial line idles high
		lcg_state       = 32'h9758;
		gpio_model      = 32'd0;
		div_model       = soc_pkg::UART_DIV_RESET;
		tx_frame_active = 1'b0;
		tests_run       = 0;
		tests_failed    = 0;
		aborted         = 1'b0;

		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;

		// First access completes only once the stretched reset is released
		bus_access({soc_pkg::REGION_GPIO, 24'd0}, 32'd0, 4'd0, rdata, waited, timed_out);
		if (timed_out) begin
			report_failure("reset_state", "no ready after reset");
			aborted = 1'b1;
		end else if (rdata !== 32'd0)
			report_value_error("reset_state", 32'd0, rdata);
		else if (leds !== '0)
			report_value_error("reset_state", 32'd0, {24'd0, leds});
		else if (ser_tx !== 1'b1)
			report_failure("reset_state", "ser_tx is not idle high");
		else
			report_ok("reset_state");

		fork
			watch_tx();
		join_none

		fd = $fopen("sim/hx8k_testdata.txt", "r");
		if (fd == 0) begin
			report_failure("testdata", "cannot open sim/hx8k_testdata.txt");
			aborted = 1'b1;
		end
		while (!aborted && $fscanf(fd, "%s", op) == 1) begin
			if (op == "#") begin
				void'($fgets(skip_line, fd));     // Comment line
			end else begin
				lcg_state = lcg_next(lcg_state);
				idle_cycles(lcg_state[17:16]);    // 0 to 3 idle cycles
				if (op == "W") begin
					void'($fscanf(fd, "%h %h %h %s", addr, data, strb, name));
					// Only a UART data write may be stalled by a frame in flight
					busy_before = tx_frame_active && addr[31:24] == soc_pkg::REGION_UART
						&& addr[23:2] == soc_pkg::UART_REG_DATA;
					bus_access(addr, data, strb, rdata, waited, timed_out);
					if (addr[31:24] == soc_pkg::REGION_GPIO)
						gpio_model = apply_strobes(gpio_model, data, strb);
					else if (addr[31:24] == soc_pkg::REGION_UART
						&& addr[23:2] == soc_pkg::UART_REG_DIV)
						div_model = apply_strobes(div_model, data, strb);
					if (timed_out) begin
						report_failure(name, "no ready within the timeout");
						aborted = 1'b1;
					end else if (leds !== gpio_model[7:0])
						report_value_error(name, {24'd0, gpio_model[7:0]}, {24'd0, leds});
					else if (busy_before && waited <= 2)
						report_failure(name, "data write was accepted while a frame was sending");
					else
						report_ok(name);
				end else if (op == "R") begin
					void'($fscanf(fd, "%h %h %s", addr, expected, name));
					if (addr[31:24] == soc_pkg::REGION_GPIO)
						expected = gpio_model;         // Readback follows the write model
					bus_access(addr, 32'd0, 4'd0, rdata, waited, timed_out);
					if (timed_out) begin
						report_failure(name, "no ready within the timeout");
						aborted = 1'b1;
					end else if (rdata !== expected)
						report_value_error(name, expected, rdata);
					else
						report_ok(name);
				end else if (op == "S") begin
					void'($fscanf(fd, "%h %s", byte_val, name));
					send_frame(byte_val);               // Checked by the next data read
				end else if (op == "T") begin
					void'($fscanf(fd, "%h %s", byte_val, name));
					waited = 0;
					while (tx_seen.size() == 0 && waited < FRAME_TIMEOUT) begin
						idle_cycles(1);
						waited++;
					end
					if (tx_seen.size() == 0) begin
						report_failure(name, "no frame on ser_tx within the timeout");
						aborted = 1'b1;
					end else begin
						got = tx_seen.pop_front();
						if (got !== byte_val)
							report_value_error(name, {24'd0, byte_val}, {24'd0, got});
						else
							report_ok(name);
					end
				end else begin
					report_failure("testdata", "unknown opcode in the data file");
					aborted = 1'b1;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		if (!aborted && tx_seen.size() != 0)
			report_failure("tx_leftover", "ser_tx sent frames that no check expected");
		if (dut.u_asserts.assert_fails != 0)
			report_failure("assertions", "a bound assertion fired");

		$display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
		if (tests_failed == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
